// ==== all.f ====
+incdir+include
hdl/periph_pkg.sv
hdl/periph_ifs.sv
hdl/periph_read_port.sv
hdl/periph_decode.sv
hdl/gpio_ctrl.sv
hdl/word_regs.sv
hdl/edge_counter.sv
hdl/tqv_periph_top.sv
verif/periph_checker.sv
verif/tb_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the peripheral hub testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_periph \
    -f all.f \
    --Mdir obj_dir \
    -o tb_periph_sim

./obj_dir/tb_periph_sim

// ==== verif/tb_periph.sv ====
// testbench for the peripheral hub: bus tasks, reference model and directed checks
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module tb_periph import periph_pkg::*; ();

    // about 350 cycles of traffic, generous margin
    localparam int CYCLE_LIMIT = 2000;

    localparam func_sel_t FN_GPIO = func_sel_t'(`SLOT_GPIO);
    localparam func_sel_t FN_WORD = func_sel_t'(`SLOT_WORD);
    localparam func_sel_t FN_EDGE = func_sel_t'({1'b1, `SIMPLE_EDGE});
    localparam byte_off_t EDGE_SEL = 4'h0;
    localparam byte_off_t EDGE_COUNT = 4'h1;

    logic    clk;
    logic    rst_n;
    byte_t   ui_in;
    byte_t   uo_out;
    logic    audio;
    logic    audio_select;
    addr_t   addr;
    data_t   data_in;
    xfer_n_t write_n;
    xfer_n_t read_n;
    data_t   data_out;
    logic    data_ready;
    logic    read_complete;
    logic    user_interrupt;

    // reference model of the visible state
    data_t      word_model [4];
    func_sel_t  fsel_model [8];
    byte_t      gpio_model;
    byte_t      edge_model;
    logic [2:0] edge_pin;
    int         cycle_count = 0;

    tqv_periph_top i_tqv_periph_top (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .o_audio              (audio),
        .o_audio_select       (audio_select),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .i_data_read_complete (read_complete),
        .o_user_interrupt     (user_interrupt)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: test still running after %0d cycles", CYCLE_LIMIT));
        end
    end

    // outputs are sampled and inputs driven 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input data_t got, input data_t exp, input string what);
        assert (got == exp) else
            abort_run($sformatf("FAIL %0t: %s, got %h expected %h", $time, what, got, exp));
    endtask

    function automatic addr_t gpio_addr(input word_off_t off);
        return {1'b0, `SLOT_GPIO, off};
    endfunction

    function automatic addr_t fsel_addr(input int pin);
        return gpio_addr(word_off_t'(`GPIO_FSEL_OFF + 4 * pin));
    endfunction

    function automatic addr_t word_addr(input int r);
        return {1'b0, `SLOT_WORD, word_off_t'(4 * r)};
    endfunction

    function automatic addr_t edge_addr(input byte_off_t off);
        return {`SIMPLE_BANK, 1'b0, `SIMPLE_EDGE, off};
    endfunction

    // bit i of the source named by pin i's function
    function automatic byte_t expected_pins();
        byte_t pins;
        pins = '0;
        for (int i = 0; i < 8; i++) begin
            case (fsel_model[i])
                FN_GPIO: pins[i] = gpio_model[i];
                FN_WORD: pins[i] = word_model[0][i];
                FN_EDGE: pins[i] = edge_model[i];
                default: pins[i] = 1'b0;
            endcase
        end
        return pins;
    endfunction

    task automatic check_pins();
        check_value(data_t'(uo_out), data_t'(expected_pins()), "pin outputs");
    endtask

    task automatic write_bus(input addr_t a, input xfer_n_t size, input data_t d);
        addr = a;
        data_in = d;
        write_n = size;
        next_cycle();
        check_value(data_t'(data_ready), 32'd1, "write ready");
        write_n = `XFER_NONE;
    endtask

    task automatic read_bus(input addr_t a, output data_t d, output int latency);
        addr = a;
        read_n = `XFER_WORD;
        latency = 0;
        do begin
            next_cycle();
            latency++;
        end while (!data_ready);
        d = data_out;
        read_n = `XFER_NONE;
        read_complete = 1'b1;
        next_cycle();
        read_complete = 1'b0;
    endtask

    task automatic read_check(input addr_t a, input data_t exp, input int exp_lat,
                              input string what);
        data_t got;
        int    lat;
        read_bus(a, got, lat);
        check_value(got, exp, what);
        check_value(data_t'(lat), data_t'(exp_lat), {what, " latency"});
    endtask

    // core stalls the completion while the pins change under the held result
    task automatic read_held(input addr_t a, input data_t exp, input byte_t new_pins,
                             input string what);
        addr = a;
        read_n = `XFER_WORD;
        do begin
            next_cycle();
        end while (!data_ready);
        ui_in = new_pins;
        repeat (3) next_cycle();
        check_value(data_out, exp, what);
        read_n = `XFER_NONE;
        read_complete = 1'b1;
        next_cycle();
        read_complete = 1'b0;
    endtask

    task automatic word_write(input int r, input xfer_n_t size, input data_t w);
        write_bus(word_addr(r), size, w);
        case (size)
            `XFER_BYTE: word_model[r][7:0] = w[7:0];
            `XFER_HALF: word_model[r][15:0] = w[15:0];
            default:    word_model[r] = w;
        endcase
        check_value(data_t'(user_interrupt), data_t'(word_model[3][0]), "interrupt");
        check_pins();
    endtask

    task automatic set_function(input int pin, input func_sel_t f);
        write_bus(fsel_addr(pin), `XFER_WORD, data_t'(f));
        fsel_model[pin] = f;
        check_pins();
    endtask

    // two cycles so the count and the registered audio both settle
    task automatic set_pins(input byte_t v);
        if (v[edge_pin] && !ui_in[edge_pin]) begin
            edge_model = edge_model + 8'd1;
        end
        ui_in = v;
        next_cycle();
        next_cycle();
        check_pins();
    endtask

    initial begin
        data_t wval;
        int    n_edges;
        void'($urandom(32'hc0e8));
        rst_n = 1'b0;
        ui_in = '0;
        addr = '0;
        data_in = '0;
        write_n = `XFER_NONE;
        read_n = `XFER_NONE;
        read_complete = 1'b0;
        for (int i = 0; i < 4; i++) begin
            word_model[i] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            fsel_model[i] = `PIN_RESET_SEL;
        end
        gpio_model = '0;
        edge_model = '0;
        edge_pin = '0;
        repeat (16) next_cycle();
        rst_n = 1'b1;
        next_cycle();

        // state after reset
        check_value(data_t'(uo_out), 32'd0, "pins after reset");
        check_value(data_t'(audio_select), 32'd0, "audio select after reset");
        check_value(data_t'(user_interrupt), 32'd0, "interrupt after reset");
        check_value(data_t'(data_ready), 32'd0, "ready after reset");
        for (int i = 0; i < 8; i++) begin
            read_check(fsel_addr(i), data_t'(FN_GPIO), 1, "function select after reset");
        end

        // GPIO output and input
        wval = $urandom;
        gpio_model = wval[7:0];
        write_bus(gpio_addr(`GPIO_OUT_OFF), `XFER_BYTE, wval);
        check_pins();
        read_check(gpio_addr(`GPIO_OUT_OFF), data_t'(gpio_model), 1, "GPIO output readback");
        set_pins(byte_t'($urandom));
        read_check(gpio_addr(`GPIO_IN_OFF), data_t'(ui_in), 1, "GPIO input readback");
        // pin 0 feeds the edge counter here, so it stays put
        read_held(gpio_addr(`GPIO_IN_OFF), data_t'(ui_in), ui_in ^ 8'hfe,
                  "GPIO input held until complete");

        // word registers at each size
        for (int r = 0; r < 4; r++) begin
            word_write(r, `XFER_BYTE, $urandom);
            read_check(word_addr(r), word_model[r], 2, "word register after byte write");
            word_write(r, `XFER_HALF, $urandom);
            read_check(word_addr(r), word_model[r], 2, "word register after half write");
            word_write(r, `XFER_WORD, $urandom);
            read_check(word_addr(r), word_model[r], 2, "word register after word write");
        end
        word_write(3, `XFER_WORD, 32'h1);
        word_write(3, `XFER_WORD, 32'h0);

        // pin function mux
        set_function(3, FN_WORD);
        read_check(fsel_addr(3), data_t'(FN_WORD), 1, "function select readback");
        word_write(0, `XFER_WORD, $urandom);
        word_write(0, `XFER_BYTE, ~word_model[0]);
        set_function(5, FN_EDGE);

        // edge counter on pin 2
        set_pins(8'h00);
        write_bus(edge_addr(EDGE_SEL), `XFER_BYTE, 32'd2);
        edge_pin = 3'd2;
        write_bus(edge_addr(EDGE_COUNT), `XFER_BYTE, 32'd0);
        edge_model = '0;
        check_pins();
        read_check(edge_addr(EDGE_SEL), 32'd2, 1, "edge pin select readback");
        n_edges = 3 + int'($urandom % 10);
        for (int k = 0; k < n_edges; k++) begin
            set_pins(8'h04);
            set_pins(8'h00);
        end
        read_check(edge_addr(EDGE_COUNT), data_t'(n_edges), 1, "edge count");
        write_bus(edge_addr(EDGE_COUNT), `XFER_BYTE, 32'd0);
        edge_model = '0;
        check_pins();
        read_check(edge_addr(EDGE_COUNT), 32'd0, 1, "edge count after clear");
        read_check({1'b0, 4'd5, 6'h00}, 32'd0, 1, "empty user slot");
        read_check({`SIMPLE_BANK, 1'b0, 4'd3, 4'h0}, 32'd0, 1, "empty simple slot");

        // audio from gpio_out bit 7, then from the edge count
        wval = $urandom | 32'h80;
        gpio_model = wval[7:0];
        write_bus(gpio_addr(`GPIO_OUT_OFF), `XFER_BYTE, wval);
        write_bus(gpio_addr(`GPIO_AUDIO_OFF), `XFER_WORD, 32'h8);
        check_value(data_t'(audio_select), 32'd1, "audio select");
        check_value(data_t'(audio), 32'd1, "audio from GPIO bit 7");
        read_check(gpio_addr(`GPIO_AUDIO_OFF), 32'h8, 1, "audio register readback");
        write_bus(gpio_addr(`GPIO_AUDIO_OFF), `XFER_WORD, 32'ha);
        for (int k = 0; k < 3; k++) begin
            set_pins(8'h04);
            check_value(data_t'(audio), data_t'(edge_model[0]), "audio from edge count");
            set_pins(8'h00);
        end
        check_value(data_t'(audio_select), 32'd1, "audio select held");

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/periph_checker.sv ====
// protocol checker for the hub top level: audio select, read data hold and GPIO read latency
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_checker import periph_pkg::*; (
    input wire     clk,
    input wire     rst_n,
    input addr_t   i_addr,
    input xfer_n_t i_data_write_n,
    input xfer_n_t i_data_read_n,
    input wire     i_data_read_complete,
    input data_t   o_data_out,
    input wire     o_data_ready,
    input wire     o_audio_select
);

    logic gpio_hit;
    logic audio_write;
    logic gpio_read_start;

    assign gpio_hit = (i_addr[10:9] != `SIMPLE_BANK) && (i_addr[9:6] == `SLOT_GPIO);
    assign audio_write = gpio_hit && (i_addr[5:0] == `GPIO_AUDIO_OFF)
                         && (i_data_write_n != `XFER_NONE);

    // GPIO read presented with nothing pending toward the core
    assign gpio_read_start = gpio_hit && (i_data_read_n != `XFER_NONE) && !o_data_ready;

    audio_select_in_reset: assert property (@(posedge clk) !rst_n |=> !o_audio_select)
        else $error("audio select is high right after a reset cycle");

    // only a write to the audio register can raise the select
    audio_select_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
        !o_audio_select && !audio_write |=> !o_audio_select)
        else $error("audio select rose without a write to the audio register");

    read_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        o_data_ready && !i_data_read_complete |=> $stable(o_data_out))
        else $error("read data changed while ready was high and not completed");

    gpio_read_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        gpio_read_start |=> o_data_ready)
        else $error("GPIO read did not get ready exactly one cycle later");

endmodule

bind tqv_periph_top periph_checker i_periph_checker (
    .clk                  (clk),
    .rst_n                (rst_n),
    .i_addr               (i_addr),
    .i_data_write_n       (i_data_write_n),
    .i_data_read_n        (i_data_read_n),
    .i_data_read_complete (i_data_read_complete),
    .o_data_out           (o_data_out),
    .o_data_ready         (o_data_ready),
    .o_audio_select       (o_audio_select)
);

`default_nettype wire

// ==== hdl/tqv_periph_top.sv ====
// peripheral hub top level: read port, decoder, GPIO and the two peripherals
`timescale 1ns/1ps
`default_nettype none

module tqv_periph_top import periph_pkg::*; (
    input  wire     clk,
    input  wire     rst_n,
    input  byte_t   i_ui_in,
    output byte_t   o_uo_out,
    output logic    o_audio,
    output logic    o_audio_select,
    input  addr_t   i_addr,
    input  data_t   i_data_in,
    input  xfer_n_t i_data_write_n,
    input  xfer_n_t i_data_read_n,
    output data_t   o_data_out,
    output logic    o_data_ready,
    input  wire     i_data_read_complete,
    output logic    o_user_interrupt
);

    xfer_n_t read_n_masked;
    data_t   peri_rdata;
    logic    peri_ready;

    word_slot_if gpio_bus ();
    word_slot_if word_bus ();
    byte_slot_if edge_bus ();

    periph_read_port u_read_port (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .i_peri_rdata         (peri_rdata),
        .i_peri_ready         (peri_ready),
        .o_read_n_masked      (read_n_masked),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    periph_decode u_decode (
        .i_addr    (i_addr),
        .i_wdata   (i_data_in),
        .i_write_n (i_data_write_n),
        .i_read_n  (read_n_masked),
        .o_rdata   (peri_rdata),
        .o_ready   (peri_ready),
        .gpio_bus  (gpio_bus.host),
        .word_bus  (word_bus.host),
        .edge_bus  (edge_bus.host)
    );

    // pin outputs of the other slots feed the GPIO mux directly
    gpio_ctrl u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus            (gpio_bus.dev),
        .i_ui_in        (i_ui_in),
        .i_word_uo      (word_bus.uo),
        .i_edge_uo      (edge_bus.uo),
        .o_uo_out       (o_uo_out),
        .o_audio        (o_audio),
        .o_audio_select (o_audio_select)
    );

    word_regs u_word_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (word_bus.dev),
        .o_irq (o_user_interrupt)
    );

    edge_counter u_edge_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (edge_bus.dev),
        .i_ui_in (i_ui_in)
    );

endmodule

`default_nettype wire

// ==== hdl/edge_counter.sv ====
// simple slot that counts rising edges on a selectable input pin
`timescale 1ns/1ps
`default_nettype none

module edge_counter import periph_pkg::*; (
    input  wire    clk,
    input  wire    rst_n,
    byte_slot_if.dev bus,
    input  byte_t  i_ui_in
);

    localparam byte_off_t SEL_OFF   = 4'h0;
    localparam byte_off_t COUNT_OFF = 4'h1;

    logic [2:0] pin_sel;
    byte_t      count;
    logic       pin_now;
    logic       pin_prev;

    assign pin_now = i_ui_in[pin_sel];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_sel  <= '0;
            count    <= '0;
            pin_prev <= 1'b0;
        end else begin
            pin_prev <= pin_now;
            if (bus.wr && bus.offset == SEL_OFF) begin
                pin_sel <= bus.wdata[2:0];
            end
            // clear wins over a coincident edge, count wraps at 255
            if (bus.wr && bus.offset == COUNT_OFF) begin
                count <= '0;
            end else if (pin_now && !pin_prev) begin
                count <= count + 8'd1;
            end
        end
    end

    always_comb begin
        case (bus.offset)
            SEL_OFF:   bus.rdata = {5'b0, pin_sel};
            COUNT_OFF: bus.rdata = count;
            default:   bus.rdata = '0;
        endcase
    end

    assign bus.uo = count;

endmodule

`default_nettype wire

// ==== hdl/word_regs.sv ====
// user slot with four 32-bit registers, one-cycle read wait and an interrupt
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module word_regs import periph_pkg::*; (
    input  wire    clk,
    input  wire    rst_n,
    word_slot_if.dev bus,
    output logic   o_irq
);

    data_t      regs [4];
    data_t      rd_data;
    logic       rd_ready;
    logic       write_live;
    logic       read_live;
    logic       reg_hit;
    logic [1:0] reg_idx;

    assign write_live = (bus.write_n != `XFER_NONE);
    assign read_live  = (bus.read_n != `XFER_NONE);

    // registers at 0x0, 0x4, 0x8, 0xc
    assign reg_hit = (bus.offset[5:4] == 2'b00) && (bus.offset[1:0] == 2'b00);
    assign reg_idx = bus.offset[3:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ready <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else begin
            rd_ready <= read_live;
            if (write_live && reg_hit) begin
                // narrow writes leave the upper bits alone
                case (bus.write_n)
                    `XFER_BYTE: regs[reg_idx][7:0]  <= bus.wdata[7:0];
                    `XFER_HALF: regs[reg_idx][15:0] <= bus.wdata[15:0];
                    default:    regs[reg_idx]       <= bus.wdata;
                endcase
            end
        end
    end

    // read data sampled with the request, presented with ready
    always_ff @(posedge clk) begin
        if (read_live) begin
            rd_data <= reg_hit ? regs[reg_idx] : '0;
        end
    end

    assign bus.rdata = rd_data;
    assign bus.ready = rd_ready;
    assign bus.uo    = regs[0][7:0];
    assign o_irq     = regs[3][0];

endmodule

`default_nettype wire

// ==== hdl/gpio_ctrl.sv ====
// GPIO slot: output register, input readback, pin function mux and audio select
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module gpio_ctrl import periph_pkg::*; (
    input  wire    clk,
    input  wire    rst_n,
    word_slot_if.dev bus,
    input  byte_t  i_ui_in,
    input  byte_t  i_word_uo,
    input  byte_t  i_edge_uo,
    output byte_t  o_uo_out,
    output logic   o_audio,
    output logic   o_audio_select
);

    byte_t      gpio_out;
    logic [3:0] audio_sel;
    func_sel_t  func_sel [8];
    logic       write_live;
    logic       fsel_hit;
    logic [2:0] fsel_pin;

    assign write_live = (bus.write_n != `XFER_NONE);
    assign fsel_hit   = ((bus.offset & `GPIO_FSEL_MASK) == `GPIO_FSEL_OFF);
    assign fsel_pin   = bus.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
            for (int i = 0; i < 8; i++) begin
                func_sel[i] <= `PIN_RESET_SEL;
            end
        end else if (write_live) begin
            if (bus.offset == `GPIO_OUT_OFF) begin
                gpio_out <= bus.wdata[7:0];
            end
            if (bus.offset == `GPIO_AUDIO_OFF) begin
                audio_sel <= bus.wdata[3:0];
            end
            if (fsel_hit) begin
                func_sel[fsel_pin] <= bus.wdata[5:0];
            end
        end
    end

    // register readback is combinational, always ready
    always_comb begin
        if (bus.offset == `GPIO_OUT_OFF) begin
            bus.rdata = {24'h0, gpio_out};
        end else if (bus.offset == `GPIO_IN_OFF) begin
            bus.rdata = {24'h0, i_ui_in};
        end else if (bus.offset == `GPIO_AUDIO_OFF) begin
            bus.rdata = {28'h0, audio_sel};
        end else if (fsel_hit) begin
            bus.rdata = {26'h0, func_sel[fsel_pin]};
        end else begin
            bus.rdata = '0;
        end
    end

    assign bus.ready = 1'b1;
    assign bus.uo    = gpio_out;

    // pin i takes bit i of whichever slot its function names
    always_comb begin
        o_uo_out = '0;
        for (int i = 0; i < 8; i++) begin
            if (func_sel[i][4]) begin
                if (func_sel[i][3:0] == `SIMPLE_EDGE) begin
                    o_uo_out[i] = i_edge_uo[i];
                end
            end else begin
                case (func_sel[i][3:0])
                    `SLOT_GPIO: o_uo_out[i] = bus.uo[i];
                    `SLOT_WORD: o_uo_out[i] = i_word_uo[i];
                    default:    o_uo_out[i] = 1'b0;
                endcase
            end
        end
    end

    // audio source table, only populated sources
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_audio <= 1'b0;
        end else begin
            case (audio_sel[2:0])
                3'd0:    o_audio <= bus.uo[7];
                3'd1:    o_audio <= i_word_uo[7];
                3'd2:    o_audio <= i_edge_uo[0];
                default: o_audio <= 1'b0;
            endcase
        end
    end

    assign o_audio_select = audio_sel[3];

endmodule

`default_nettype wire

// ==== hdl/periph_decode.sv ====
// address decode, request gating and read-data / ready mux for all slots
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_decode import periph_pkg::*; (
    input  addr_t   i_addr,
    input  data_t   i_wdata,
    input  xfer_n_t i_write_n,
    input  xfer_n_t i_read_n,
    output data_t   o_rdata,
    output logic    o_ready,
    word_slot_if.host gpio_bus,
    word_slot_if.host word_bus,
    byte_slot_if.host edge_bus
);

    logic  simple_hit;
    slot_t user_slot;
    slot_t simple_slot;
    logic  gpio_sel;
    logic  word_sel;
    logic  edge_sel;

    assign simple_hit  = (i_addr[10:9] == `SIMPLE_BANK);
    assign user_slot   = i_addr[9:6];
    assign simple_slot = i_addr[7:4];

    assign gpio_sel = !simple_hit && (user_slot == `SLOT_GPIO);
    assign word_sel = !simple_hit && (user_slot == `SLOT_WORD);
    assign edge_sel = simple_hit && (simple_slot == `SIMPLE_EDGE);

    // user slots see idle requests unless selected
    assign gpio_bus.offset  = i_addr[5:0];
    assign gpio_bus.wdata   = i_wdata;
    assign gpio_bus.write_n = gpio_sel ? i_write_n : `XFER_NONE;
    assign gpio_bus.read_n  = gpio_sel ? i_read_n : `XFER_NONE;

    assign word_bus.offset  = i_addr[5:0];
    assign word_bus.wdata   = i_wdata;
    assign word_bus.write_n = word_sel ? i_write_n : `XFER_NONE;
    assign word_bus.read_n  = word_sel ? i_read_n : `XFER_NONE;

    // simple slots only get a byte write strobe
    assign edge_bus.offset = i_addr[3:0];
    assign edge_bus.wdata  = i_wdata[7:0];
    assign edge_bus.wr     = edge_sel && (i_write_n != `XFER_NONE);

    always_comb begin
        o_rdata = '0;
        o_ready = 1'b1;
        if (simple_hit) begin
            // simple slots are byte wide, zero-extended
            if (edge_sel) begin
                o_rdata = {24'h0, edge_bus.rdata};
            end
        end else begin
            case (user_slot)
                `SLOT_GPIO: begin
                    o_rdata = gpio_bus.rdata;
                    o_ready = gpio_bus.ready;
                end
                `SLOT_WORD: begin
                    o_rdata = word_bus.rdata;
                    o_ready = word_bus.ready;
                end
                // empty slot answers at once with zero
                default: begin
                    o_rdata = '0;
                    o_ready = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/periph_read_port.sv ====
// read-data register toward the core with hold-until-complete and ready
`timescale 1ns/1ps
`default_nettype none
`include "periph_settings.svh"

module periph_read_port import periph_pkg::*; (
    input  wire     clk,
    input  wire     rst_n,
    input  xfer_n_t i_data_read_n,
    input  xfer_n_t i_data_write_n,
    input  wire     i_data_read_complete,
    input  data_t   i_peri_rdata,
    input  wire     i_peri_ready,
    output xfer_n_t o_read_n_masked,
    output data_t   o_data_out,
    output logic    o_data_ready
);

    logic  read_live;
    logic  write_live;
    logic  capture;
    logic  hold;
    logic  ready_r;
    data_t data_r;

    assign read_live  = (i_data_read_n != `XFER_NONE);
    assign write_live = (i_data_write_n != `XFER_NONE);

    // first ready of a read loads the register, later ones are ignored
    assign capture = !hold && i_peri_ready && read_live;

    // no new request reaches the slot while the result is presented
    assign o_read_n_masked = i_data_read_n | {2{ready_r}};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold <= 1'b0;
            end
            // a fresh capture overrides a completion in the same cycle
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= read_live && i_peri_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_peri_rdata;
        end
    end

    assign o_data_out = data_r;

    // writes complete in the cycle they are presented
    assign o_data_ready = ready_r || write_live;

endmodule

`default_nettype wire

// ==== hdl/periph_ifs.sv ====
// slot interfaces between the address decoder and the peripherals
`timescale 1ns/1ps
`default_nettype none

// full user slot with sized requests and a ready
interface word_slot_if;
    periph_pkg::word_off_t offset;
    periph_pkg::data_t     wdata;
    periph_pkg::xfer_n_t   write_n;
    periph_pkg::xfer_n_t   read_n;
    periph_pkg::data_t     rdata;
    logic                  ready;
    periph_pkg::byte_t     uo;

    modport host (
        output offset,
        output wdata,
        output write_n,
        output read_n,
        input  rdata,
        input  ready
    );

    modport dev (
        input  offset,
        input  wdata,
        input  write_n,
        input  read_n,
        output rdata,
        output ready,
        output uo
    );
endinterface

// byte-wide simple slot, reads are always ready
interface byte_slot_if;
    periph_pkg::byte_off_t offset;
    logic                  wr;
    periph_pkg::byte_t     wdata;
    periph_pkg::byte_t     rdata;
    periph_pkg::byte_t     uo;

    modport host (
        output offset,
        output wr,
        output wdata,
        input  rdata
    );

    modport dev (
        input  offset,
        input  wr,
        input  wdata,
        output rdata,
        output uo
    );
endinterface

`default_nettype wire

// ==== hdl/periph_pkg.sv ====
// shared width types for the peripheral hub
`default_nettype none

package periph_pkg;

    // bus address from the core
    typedef logic [10:0] addr_t;

    // bus data, 8/16/32 bits valid depending on request size
    typedef logic [31:0] data_t;

    // pin and simple slot data
    typedef logic [7:0] byte_t;

    // request code, 11 is idle
    typedef logic [1:0] xfer_n_t;

    // slot index within a bank
    typedef logic [3:0] slot_t;

    // bit 4 picks the simple bank, bits 3..0 the slot
    typedef logic [5:0] func_sel_t;

    // offsets inside user and simple slots
    typedef logic [5:0] word_off_t;
    typedef logic [3:0] byte_off_t;

endpackage

`default_nettype wire

// ==== include/periph_settings.svh ====
// peripheral hub settings: address map, slot numbers and GPIO register layout
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// request codes on write_n / read_n
`define XFER_NONE 2'b11
`define XFER_BYTE 2'b00
`define XFER_HALF 2'b01
`define XFER_WORD 2'b10

// addr[10:9] value that selects the simple bank
`define SIMPLE_BANK 2'b10

// user slots, 64 bytes each at addr[9:6]
`define SLOT_GPIO 4'd1
`define SLOT_WORD 4'd2

// simple slots, 16 bytes each at addr[7:4]
`define SIMPLE_EDGE 4'd0

// GPIO register offsets inside its slot
`define GPIO_OUT_OFF 6'h00
`define GPIO_IN_OFF 6'h04
`define GPIO_AUDIO_OFF 6'h10

// function selects live at 0x20 + 4 * pin
`define GPIO_FSEL_OFF 6'h20
`define GPIO_FSEL_MASK 6'h23

// user bank, GPIO slot
`define PIN_RESET_SEL 6'h01

`endif
